/* hdl/systolic_pkg.sv */
`default_nettype none

package systolic_pkg;

	////////////////////////////////////////////////////////////
	// Array geometry
	////////////////////////////////////////////////////////////

	localparam int DATA_W = 8;
	localparam int N_ROWS = 3;
	localparam int N_COLS = 4;
	// One oblique lane per diagonal of the bank
	localparam int N_OBLI = N_ROWS + N_COLS - 1;

	// Full-width partial sum, product plus row growth
	localparam int ACC_W = 2 * DATA_W + $clog2(N_ROWS);
	localparam int COL_IDX_W = $clog2(N_COLS);

	////////////////////////////////////////////////////////////
	// Buffering and latency
	////////////////////////////////////////////////////////////

	localparam int FIFO_DEPTH = 16;
	// One register stage per row
	localparam int BANK_LATENCY = N_ROWS;
	// Sets between a pop and the result FIFO write
	localparam int IN_FLIGHT_MAX = BANK_LATENCY + 1;

	////////////////////////////////////////////////////////////
	// Payload types
	////////////////////////////////////////////////////////////

	typedef logic [DATA_W-1:0] data_t;

	typedef struct packed {
		data_t [N_OBLI-1:0] obli;
		data_t [N_ROWS-1:0] horz;
	} operand_t;

	// col[0] sits in the low byte and leaves first
	typedef struct packed {
		data_t [N_COLS-1:0] col;
	} out_row_t;

endpackage

`default_nettype wire

/* hdl/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic wr_en,
	input wire payload_t wr_data,
	input wire logic rd_en,
	output payload_t rd_data,
	output logic empty,
	output logic almost_full,
	output logic [$clog2(DEPTH+1)-1:0] free
);

	localparam int AW = $clog2(DEPTH);
	localparam int CW = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;

	always_ff @(posedge clk) begin
		if (!rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage and read port
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_ptr];
		end
	end

	assign empty = (count == '0);
	assign almost_full = (count >= CW'(DEPTH - 1));
	assign free = CW'(DEPTH) - count;

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
		!(wr_en && !rd_en && count == CW'(DEPTH)))
		else $error("stream_fifo write while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (!rst)
		!(rd_en && empty))
		else $error("stream_fifo read while empty");

endmodule

`default_nettype wire

/* hdl/operand_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_feeder (
	input wire logic clk,
	input wire logic rst,
	input wire systolic_pkg::data_t [systolic_pkg::N_ROWS-1:0] horz_data,
	input wire logic [systolic_pkg::N_ROWS-1:0] horz_we,
	output logic [systolic_pkg::N_ROWS-1:0] horz_wrdy,
	input wire systolic_pkg::data_t [systolic_pkg::N_OBLI-1:0] obli_data,
	input wire logic [systolic_pkg::N_OBLI-1:0] obli_we,
	output logic [systolic_pkg::N_OBLI-1:0] obli_wrdy,
	input wire logic result_room,
	output systolic_pkg::operand_t operands,
	output logic operand_en
);

	import systolic_pkg::*;

	data_t horz_q [N_ROWS];
	data_t obli_q [N_OBLI];
	logic [N_ROWS-1:0] horz_empty;
	logic [N_OBLI-1:0] obli_empty;
	logic [N_ROWS-1:0] horz_afull;
	logic [N_OBLI-1:0] obli_afull;
	logic pop;

	////////////////////////////////////////////////////////////
	// Lane buffers
	////////////////////////////////////////////////////////////

	for (genvar r = 0; r < N_ROWS; r++) begin : g_horz
		stream_fifo #(
			.payload_t(data_t),
			.DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk(clk),
			.rst(rst),
			.wr_en(horz_we[r]),
			.wr_data(horz_data[r]),
			.rd_en(pop),
			.rd_data(horz_q[r]),
			.empty(horz_empty[r]),
			.almost_full(horz_afull[r]),
			.free()
		);
	end

	for (genvar k = 0; k < N_OBLI; k++) begin : g_obli
		stream_fifo #(
			.payload_t(data_t),
			.DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk(clk),
			.rst(rst),
			.wr_en(obli_we[k]),
			.wr_data(obli_data[k]),
			.rd_en(pop),
			.rd_data(obli_q[k]),
			.empty(obli_empty[k]),
			.almost_full(obli_afull[k]),
			.free()
		);
	end

	assign horz_wrdy = ~horz_afull;
	assign obli_wrdy = ~obli_afull;

	////////////////////////////////////////////////////////////
	// Pop decision
	////////////////////////////////////////////////////////////

	// All nine lanes move together
	assign pop = ~(|horz_empty) & ~(|obli_empty) & result_room;

	// Read data lands one cycle after the pop
	always_ff @(posedge clk) begin
		if (!rst) begin
			operand_en <= 1'b0;
		end else begin
			operand_en <= pop;
		end
	end

	always_comb begin
		for (int r = 0; r < N_ROWS; r++) begin
			operands.horz[r] = horz_q[r];
		end
		for (int k = 0; k < N_OBLI; k++) begin
			operands.obli[k] = obli_q[k];
		end
	end

endmodule

`default_nettype wire

/* hdl/conv_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_bank (
	input wire logic clk,
	input wire logic rst,
	input wire systolic_pkg::operand_t operands,
	input wire logic operand_en,
	output systolic_pkg::out_row_t row,
	output logic row_en
);

	import systolic_pkg::*;

	// Stage r holds the sums over rows 0..r
	logic [N_ROWS-1:0] stage_en;
	logic [ACC_W-1:0] stage_sum [N_ROWS][N_COLS];
	// Operands travelling with the sums, last stage needs none
	operand_t stage_ops [N_ROWS-1];

	////////////////////////////////////////////////////////////
	// Valid pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			stage_en <= '0;
		end else begin
			stage_en <= {stage_en[N_ROWS-2:0], operand_en};
		end
	end

	////////////////////////////////////////////////////////////
	// Operand pipeline
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (operand_en) begin
			stage_ops[0] <= operands;
		end
		for (int r = 1; r < N_ROWS - 1; r++) begin
			if (stage_en[r-1]) begin
				stage_ops[r] <= stage_ops[r-1];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Multiply-accumulate
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// Row 0 starts each column sum
		if (operand_en) begin
			for (int c = 0; c < N_COLS; c++) begin
				stage_sum[0][c] <= operands.horz[0] * operands.obli[c];
			end
		end
		// Column c of row r reads the oblique lane r+c
		for (int r = 1; r < N_ROWS; r++) begin
			if (stage_en[r-1]) begin
				for (int c = 0; c < N_COLS; c++) begin
					stage_sum[r][c] <= stage_sum[r-1][c]
						+ stage_ops[r-1].horz[r] * stage_ops[r-1].obli[r+c];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Row output
	////////////////////////////////////////////////////////////

	// Only the low byte survives, wrapping
	always_comb begin
		for (int c = 0; c < N_COLS; c++) begin
			row.col[c] = stage_sum[N_ROWS-1][c][DATA_W-1:0];
		end
	end

	assign row_en = stage_en[N_ROWS-1];

endmodule

`default_nettype wire

/* hdl/result_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module result_serializer (
	input wire logic clk,
	input wire logic rst,
	input wire systolic_pkg::out_row_t row,
	input wire logic row_en,
	output logic result_room,
	output systolic_pkg::data_t dout,
	output logic dout_en
);

	import systolic_pkg::*;

	out_row_t fifo_row;
	out_row_t shift_reg;
	logic fifo_empty;
	logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_free;
	logic load;
	logic fill;
	logic [COL_IDX_W-1:0] shift_cnt;

	stream_fifo #(
		.payload_t(out_row_t),
		.DEPTH(FIFO_DEPTH)
	) u_result_fifo (
		.clk(clk),
		.rst(rst),
		.wr_en(row_en),
		.wr_data(row),
		.rd_en(load),
		.rd_data(fifo_row),
		.empty(fifo_empty),
		.almost_full(),
		.free(fifo_free)
	);

	// Room for every set that may still be inside the bank
	assign result_room = (fifo_free > IN_FLIGHT_MAX);

	////////////////////////////////////////////////////////////
	// Load and shift
	////////////////////////////////////////////////////////////

	assign load = !fifo_empty && !fill && !dout_en;

	always_ff @(posedge clk) begin
		if (!rst) begin
			fill <= 1'b0;
			dout_en <= 1'b0;
			shift_cnt <= '0;
		end else begin
			fill <= load;
			if (fill) begin
				dout_en <= 1'b1;
			end else if (shift_cnt == COL_IDX_W'(N_COLS - 1)) begin
				dout_en <= 1'b0;
			end
			if (dout_en) begin
				shift_cnt <= shift_cnt + 1'b1;
			end
		end
	end

	// FIFO read data is valid in the fill cycle
	always_ff @(posedge clk) begin
		if (fill) begin
			shift_reg <= fifo_row;
		end else if (dout_en) begin
			shift_reg <= out_row_t'(shift_reg >> DATA_W);
		end
	end

	assign dout = shift_reg.col[0];

	a_burst_max: assert property (@(posedge clk) disable iff (!rst)
		dout_en [*N_COLS] |=> !dout_en)
		else $error("dout_en longer than one row");

	a_load_burst: assert property (@(posedge clk) disable iff (!rst)
		load |-> ##2 dout_en [*N_COLS])
		else $error("loaded row did not produce a full burst");

endmodule

`default_nettype wire

/* hdl/systolic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_top (
	input wire logic clk,
	input wire logic rst,
	input wire systolic_pkg::data_t [systolic_pkg::N_ROWS-1:0] horz_data,
	input wire logic [systolic_pkg::N_ROWS-1:0] horz_we,
	output logic [systolic_pkg::N_ROWS-1:0] horz_wrdy,
	input wire systolic_pkg::data_t [systolic_pkg::N_OBLI-1:0] obli_data,
	input wire logic [systolic_pkg::N_OBLI-1:0] obli_we,
	output logic [systolic_pkg::N_OBLI-1:0] obli_wrdy,
	output systolic_pkg::data_t dout,
	output logic dout_en
);

	import systolic_pkg::*;

	operand_t operands;
	logic operand_en;
	out_row_t row;
	logic row_en;
	logic result_room;

	operand_feeder u_operand_feeder (
		.clk(clk),
		.rst(rst),
		.horz_data(horz_data),
		.horz_we(horz_we),
		.horz_wrdy(horz_wrdy),
		.obli_data(obli_data),
		.obli_we(obli_we),
		.obli_wrdy(obli_wrdy),
		.result_room(result_room),
		.operands(operands),
		.operand_en(operand_en)
	);

	conv_bank u_conv_bank (
		.clk(clk),
		.rst(rst),
		.operands(operands),
		.operand_en(operand_en),
		.row(row),
		.row_en(row_en)
	);

	// Drains rows and throttles the feeder
	result_serializer u_result_serializer (
		.clk(clk),
		.rst(rst),
		.row(row),
		.row_en(row_en),
		.result_room(result_room),
		.dout(dout),
		.dout_en(dout_en)
	);

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
	output logic clk
);

	localparam realtime HALF_PERIOD = 5ns;

	initial clk = 1'b0;

	// 10 ns period
	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

/* test/systolic_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module systolic_top_tb;

	import systolic_pkg::*;

	localparam int TIMEOUT_CYCLES = 4000;
	localparam int N_ARITH_SETS = 60;
	localparam int N_STALL_SETS = 20;
	localparam int N_BURST_SETS = 40;

	logic clk;
	logic rst;
	data_t [N_ROWS-1:0] horz_data;
	logic [N_ROWS-1:0] horz_we;
	logic [N_ROWS-1:0] horz_wrdy;
	data_t [N_OBLI-1:0] obli_data;
	logic [N_OBLI-1:0] obli_we;
	logic [N_OBLI-1:0] obli_wrdy;
	data_t dout;
	logic dout_en;

	// Values waiting to be written into each lane
	data_t horz_pend [N_ROWS][$];
	data_t obli_pend [N_OBLI][$];
	// Expected bytes in output order
	data_t exp_q [$];
	logic idle_window;
	logic stall_window;
	logic lane5_hold;
	int horz_count [N_ROWS];
	int run_len = 0;
	int cycle_count = 0;

	tb_clock u_tb_clock (
		.clk(clk)
	);

	systolic_top u_systolic_top (
		.clk(clk),
		.rst(rst),
		.horz_data(horz_data),
		.horz_we(horz_we),
		.horz_wrdy(horz_wrdy),
		.obli_data(obli_data),
		.obli_we(obli_we),
		.obli_wrdy(obli_wrdy),
		.dout(dout),
		.dout_en(dout_en)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////

	// Column c keeps the low byte of the sum over r of horz[r] * obli[r+c]
	task automatic queue_set();
		data_t h [N_ROWS];
		data_t o [N_OBLI];
		int sum;
		for (int r = 0; r < N_ROWS; r++) begin
			h[r] = data_t'($urandom);
			horz_pend[r].push_back(h[r]);
		end
		for (int k = 0; k < N_OBLI; k++) begin
			o[k] = data_t'($urandom);
			obli_pend[k].push_back(o[k]);
		end
		for (int c = 0; c < N_COLS; c++) begin
			sum = 0;
			for (int r = 0; r < N_ROWS; r++) begin
				sum = sum + int'(h[r]) * int'(o[r+c]);
			end
			exp_q.push_back(data_t'(sum & 'hff));
		end
	endtask

	// One cycle of lane writes gated by each lane's wrdy
	task automatic drive_step(input int we_pct);
		@(posedge clk);
		#1;
		for (int r = 0; r < N_ROWS; r++) begin
			if (horz_pend[r].size() > 0 && horz_wrdy[r] && $urandom_range(99) < we_pct) begin
				horz_we[r] = 1'b1;
				horz_data[r] = horz_pend[r].pop_front();
			end else begin
				horz_we[r] = 1'b0;
			end
		end
		for (int k = 0; k < N_OBLI; k++) begin
			if (obli_pend[k].size() > 0 && obli_wrdy[k] && $urandom_range(99) < we_pct
					&& !(lane5_hold && k == N_OBLI - 1)) begin
				obli_we[k] = 1'b1;
				obli_data[k] = obli_pend[k].pop_front();
			end else begin
				obli_we[k] = 1'b0;
			end
		end
	endtask

	function automatic bit lanes_pending();
		bit busy;
		busy = 1'b0;
		for (int r = 0; r < N_ROWS; r++) begin
			busy = busy | (horz_pend[r].size() > 0);
		end
		for (int k = 0; k < N_OBLI; k++) begin
			busy = busy | (obli_pend[k].size() > 0);
		end
		return busy;
	endfunction

	task automatic drain_all(input int we_pct);
		while (lanes_pending()) begin
			drive_step(we_pct);
		end
		drive_step(0);
		while (exp_q.size() > 0) begin
			@(posedge clk);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Occupancy of the horizontal lanes while nothing is popped
	always @(posedge clk) begin
		for (int r = 0; r < N_ROWS; r++) begin
			if (!stall_window) begin
				horz_count[r] <= 0;
			end else if (horz_we[r]) begin
				horz_count[r] <= horz_count[r] + 1;
			end
		end
	end

	always @(negedge clk) begin : check_outputs
		data_t exp_byte;
		if (idle_window) begin
			assert (!dout_en && &horz_wrdy && &obli_wrdy)
				else fail_run("Outputs left their reset state before any write");
		end
		if (stall_window) begin
			assert (!dout_en)
				else fail_run("Output appeared while oblique lane 5 was empty");
			for (int r = 0; r < N_ROWS; r++) begin
				assert (horz_wrdy[r] == (horz_count[r] < FIFO_DEPTH - 1))
					else fail_run($sformatf(
						"FAILED time=%0t signal=horz_wrdy[%0d] expected=%0b actual=%0b",
						$time, r, horz_count[r] < FIFO_DEPTH - 1, horz_wrdy[r]));
			end
		end
		if (rst && dout_en) begin
			assert (exp_q.size() > 0)
				else fail_run("Byte on dout with no set outstanding");
			exp_byte = exp_q.pop_front();
			assert (dout == exp_byte)
				else fail_run($sformatf("FAILED time=%0t signal=dout expected=%02h actual=%02h",
					$time, exp_byte, dout));
		end
		// Burst length
		if (rst && dout_en) begin
			run_len = run_len + 1;
			assert (run_len <= N_COLS)
				else fail_run("dout_en stayed high longer than one row");
		end else begin
			if (run_len != 0) begin
				assert (run_len == N_COLS)
					else fail_run($sformatf("dout_en burst of %0d cycles, not %0d",
						run_len, N_COLS));
			end
			run_len = 0;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			fail_run($sformatf("Timeout, run went past %0d cycles", TIMEOUT_CYCLES));
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(54885));
		rst = 1'b0;
		horz_we = '0;
		obli_we = '0;
		horz_data = '0;
		obli_data = '0;
		idle_window = 1'b0;
		stall_window = 1'b0;
		lane5_hold = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b1;
		idle_window = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		idle_window = 1'b0;

		// Random sets with uneven lane writes
		repeat (N_ARITH_SETS) queue_set();
		drain_all(70);

		// Lane 5 held back until the other lanes are full
		stall_window = 1'b1;
		lane5_hold = 1'b1;
		repeat (N_STALL_SETS) queue_set();
		do begin
			drive_step(100);
		end while (horz_wrdy != '0 || obli_wrdy[N_OBLI-2:0] != '0);
		repeat (20) drive_step(0);
		stall_window = 1'b0;
		lane5_hold = 1'b0;
		drain_all(100);

		// Back to back sets throttled by the result FIFO
		repeat (N_BURST_SETS) queue_set();
		drain_all(100);

		// Quiet tail so that a stray byte still hits the empty queue
		repeat (10) @(posedge clk);
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* systolic.f */
hdl/systolic_pkg.sv
hdl/stream_fifo.sv
hdl/operand_feeder.sv
hdl/conv_bank.sv
hdl/result_serializer.sv
hdl/systolic_top.sv
test/tb_clock.sv
test/systolic_top_tb.sv

/* Bender.yml */
package:
  name: systolic

sources:
  - files:
      - hdl/systolic_pkg.sv
      - hdl/stream_fifo.sv
      - hdl/operand_feeder.sv
      - hdl/conv_bank.sv
      - hdl/result_serializer.sv
      - hdl/systolic_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/systolic_top_tb.sv
